/* common/matrix_pkg.sv */
//--------------------------------------------------------------------------
// Vector-06C keyboard matrix definitions
// matrix geometry, decoder key classes, controller states and the
// constants of the released-shift hold window
//--------------------------------------------------------------------------
`default_nettype none

package matrix_pkg;

	// 8 rows of 8 keys
	localparam int matrix_rows = 8;

	typedef logic [2:0] row_t;
	typedef logic [2:0] col_t;
	typedef logic [7:0] row_bits_t;

	// what the decoder made of a scan code
	typedef enum logic [2:0] {
		class_matrix,
		class_shift,
		class_ctrl,
		class_rus,
		class_blksbr,
		class_prefix,
		class_arrow,
		class_none
	} key_class_e;

	// make path first, break path after the F0 prefix
	typedef enum logic [2:0] {
		wait_make,
		fetch_make,
		apply_make,
		wait_break,
		fetch_break,
		apply_break
	} matrix_state_e;

	//----------------------------------------------------------------------
	// shift hold window
	//----------------------------------------------------------------------

	// slow tick once every 2**hold_div_bits clocks
	localparam int hold_div_bits = 9;

	typedef logic [7:0] hold_count_t;

	// window length in slow ticks
	localparam hold_count_t hold_ticks = 8'd255;

endpackage

`default_nettype wire

/* common/ps2_pkg.sv */
//--------------------------------------------------------------------------
// PS/2 keyboard definitions
// frame layout constants, receiver states and the scan codes that the
// decoder and the matrix controller treat by name
//--------------------------------------------------------------------------
`default_nettype none

package ps2_pkg;

	// one received byte
	typedef logic [7:0] scan_code_t;

	// deframer states, start bit is checked in idle
	typedef enum logic [1:0] {
		idle,
		data,
		parity,
		stop
	} ps2_rx_state_e;

	// prefixes
	localparam scan_code_t sc_release  = 8'hF0;
	localparam scan_code_t sc_extended = 8'hE0;

	// modifiers
	localparam scan_code_t sc_lshift   = 8'h12;
	localparam scan_code_t sc_rshift   = 8'h59;
	localparam scan_code_t sc_ctrl     = 8'h14;
	// caps lock doubles as RUS/LAT
	localparam scan_code_t sc_rus      = 8'h58;
	// F12 acts as BLK+SBR
	localparam scan_code_t sc_blksbr   = 8'h07;

	// grey arrows, sent after the E0 prefix
	localparam scan_code_t sc_up       = 8'h75;
	localparam scan_code_t sc_down     = 8'h72;
	localparam scan_code_t sc_left     = 8'h6B;
	localparam scan_code_t sc_right    = 8'h74;

	// equal samples needed before the clock level is accepted
	localparam int ps2_filter_len = 4;

endpackage

`default_nettype wire

/* keyboard/keyboard_matrix.sv */
//--------------------------------------------------------------------------
// Keyboard matrix controller
// tracks make and break codes, keeps the 8x8 key matrix and the modifier
// flags and answers the host row select with the OR of selected rows
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module keyboard_matrix (
	input  logic                   clkk,
	input  logic                   reset,
	// receiver handshake
	input  ps2_pkg::scan_code_t    code,
	input  logic                   code_ready,
	output logic                   code_read,
	// decoder results
	input  matrix_pkg::key_class_e key_class,
	input  matrix_pkg::row_t       row,
	input  matrix_pkg::col_t       col,
	input  logic                   needs_shift,
	input  logic                   not_in_matrix,
	// shift hold
	input  logic                   shift_held,
	output logic                   shift_released,
	output logic                   held_shift,
	// host side
	input  matrix_pkg::row_bits_t  rowselect,
	output matrix_pkg::row_bits_t  rowbits,
	output logic                   key_shift,
	output logic                   key_ctrl,
	output logic                   key_rus,
	output logic                   key_blksbr
);
	import ps2_pkg::*;
	import matrix_pkg::*;

	matrix_state_e state;
	row_bits_t keymatrix [matrix_rows];

	// column decode, then the latched copy used by apply
	row_bits_t col_dec;
	row_bits_t col_mask;
	row_t row_q;
	row_bits_t row_tmp;
	logic release_q;

	// sticky shift from keys that need the opposite shift
	logic matrix_shift;
	row_bits_t sel_or;

	assign col_dec = row_bits_t'(1) << col;

	//----------------------------------------------------------------------
	// make/break FSM
	//----------------------------------------------------------------------

	always_ff @(posedge clkk) begin
		if (reset) begin
			state          <= wait_make;
			code_read      <= 1'b0;
			shift_released <= 1'b0;
			held_shift     <= 1'b0;
			matrix_shift   <= 1'b0;
			key_ctrl       <= 1'b0;
			key_rus        <= 1'b0;
			key_blksbr     <= 1'b0;
			for (int r = 0; r < matrix_rows; r++)
				keymatrix[r] <= '0;
		end else begin
			// single-cycle pulse
			shift_released <= 1'b0;
			case (state)
				wait_make, wait_break: begin
					if (code_ready) begin
						code_read <= 1'b1;
						state     <= (state == wait_make) ? fetch_make : fetch_break;
					end
				end
				fetch_make, fetch_break: begin
					// first cycle drops the strobe while the decoder settles
					if (code_read) begin
						code_read <= 1'b0;
					end else begin
						row_q     <= row;
						row_tmp   <= keymatrix[row];
						col_mask  <= col_dec;
						release_q <= (code == sc_release);
						state     <= (state == fetch_make) ? apply_make : apply_break;
					end
				end
				apply_make: begin
					state <= wait_make;
					case (key_class)
						class_shift:  held_shift <= 1'b1;
						class_ctrl:   key_ctrl   <= 1'b1;
						class_rus:    key_rus    <= 1'b1;
						class_blksbr: key_blksbr <= 1'b1;
						class_prefix: begin
							// E0 alone is ignored, F0 waits for the key
							if (release_q)
								state <= wait_break;
						end
						default: begin
							// arrow after a shift break keeps the held shift
							if (key_class == class_arrow)
								held_shift <= shift_held;
							if (!not_in_matrix) begin
								keymatrix[row_q] <= row_tmp | col_mask;
								matrix_shift     <= matrix_shift | needs_shift;
							end
						end
					endcase
				end
				apply_break: begin
					state <= wait_make;
					case (key_class)
						class_shift: begin
							held_shift     <= 1'b0;
							shift_released <= 1'b1;
						end
						class_ctrl:   key_ctrl   <= 1'b0;
						class_rus:    key_rus    <= 1'b0;
						class_blksbr: key_blksbr <= 1'b0;
						class_prefix: ;
						default: begin
							if (!not_in_matrix) begin
								keymatrix[row_q] <= row_tmp & ~col_mask;
								matrix_shift     <= 1'b0;
							end
						end
					endcase
				end
				default: state <= wait_make;
			endcase
		end
	end

	// matrix shift flips the physical shift
	assign key_shift = held_shift ^ matrix_shift;

	//----------------------------------------------------------------------
	// host readout
	//----------------------------------------------------------------------

	always_comb begin
		sel_or = '0;
		for (int r = 0; r < matrix_rows; r++)
			if (rowselect[r])
				sel_or = sel_or | keymatrix[r];
	end

	always_ff @(posedge clkk) begin
		rowbits <= sel_or;
	end

	// only table keys and arrows may be written into the matrix
	assert property (@(posedge clkk) disable iff (reset)
		(state == apply_make || state == apply_break) |->
			(not_in_matrix == !(key_class inside {class_matrix, class_arrow})));

endmodule

`default_nettype wire

/* ps2/ps2_receiver.sv */
//--------------------------------------------------------------------------
// PS/2 receiver
// synchronizes and filters the keyboard clock and data lines and turns
// 11-bit frames into scan codes with a ready/read handshake
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ps2_receiver (
	input  logic                clkk,
	input  logic                reset,
	input  logic                ps2_clk,
	input  logic                ps2_dat,
	output ps2_pkg::scan_code_t code,
	output logic                code_ready,
	input  logic                code_read
);
	import ps2_pkg::*;

	// two-stage synchronizers, line idles high
	logic [1:0] clk_sync;
	logic [1:0] dat_sync;

	// clock glitch filter
	logic [ps2_filter_len-1:0] clk_hist;
	logic clk_filt;
	logic clk_fall;

	// deframer
	ps2_rx_state_e state;
	logic [2:0] bit_cnt;
	scan_code_t shreg;
	logic parity_ok;

	always_ff @(posedge clkk) begin
		if (reset) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
		end
	end

	//----------------------------------------------------------------------
	// clock filter
	//----------------------------------------------------------------------

	// level changes only after ps2_filter_len equal samples
	always_ff @(posedge clkk) begin
		if (reset) begin
			clk_hist <= '1;
			clk_filt <= 1'b1;
		end else begin
			clk_hist <= {clk_hist[ps2_filter_len-2:0], clk_sync[1]};
			if (&clk_hist)
				clk_filt <= 1'b1;
			else if (~|clk_hist)
				clk_filt <= 1'b0;
		end
	end

	// one-cycle strobe on the filtered falling edge
	assign clk_fall = clk_filt & ~|clk_hist;

	//----------------------------------------------------------------------
	// deframer
	//----------------------------------------------------------------------

	always_ff @(posedge clkk) begin
		if (reset) begin
			state      <= idle;
			bit_cnt    <= '0;
			code_ready <= 1'b0;
		end else begin
			// read strobe drops ready on the following cycle
			if (code_read)
				code_ready <= 1'b0;
			if (clk_fall) begin
				case (state)
					idle: begin
						// start bit must be low, otherwise stay put
						if (!dat_sync[1]) begin
							bit_cnt <= '0;
							state   <= data;
						end
					end
					data: begin
						// LSB first
						shreg   <= {dat_sync[1], shreg[7:1]};
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= parity;
					end
					parity: begin
						// odd parity over data and parity bit
						parity_ok <= ^{shreg, dat_sync[1]};
						state     <= stop;
					end
					stop: begin
						// a bad frame is simply dropped
						if (dat_sync[1] && parity_ok) begin
							code       <= shreg;
							code_ready <= 1'b1;
						end
						state <= idle;
					end
					default: state <= idle;
				endcase
			end
		end
	end

	// the controller only reads a byte that is on offer
	assert property (@(posedge clkk) disable iff (reset) code_read |-> code_ready);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the Vector-06C keyboard testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

top=tb_vector_keyboard
log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
	-f sim.f --top-module "$top" -o "$top"; then
	echo "build failed"
	exit 1
fi

"./obj_dir/$top" > "$log" 2>&1
status=$?
cat "$log"

if grep -qF '*** TEST FAILED ***' "$log"; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

/* sim.f */
common/ps2_pkg.sv
common/matrix_pkg.sv
ps2/ps2_receiver.sv
src/scan_decoder.sv
src/shift_hold_timer.sv
keyboard/keyboard_matrix.sv
src/vector_keyboard.sv
test/tb_vector_keyboard.sv

/* src/scan_decoder.sv */
//--------------------------------------------------------------------------
// Scan code decoder
// classifies a scan code and looks up its matrix row, column and shift
// attribute, results registered one cycle after the inputs
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module scan_decoder (
	input  logic                   clkk,
	input  ps2_pkg::scan_code_t    code,
	input  logic                   shift,
	input  logic                   mod_rus,
	output matrix_pkg::key_class_e key_class,
	output matrix_pkg::row_t       row,
	output matrix_pkg::col_t       col,
	output logic                   needs_shift,
	output logic                   not_in_matrix
);
	import ps2_pkg::*;
	import matrix_pkg::*;

	// table entry, {hit, row, col}
	logic [6:0] entry;
	logic       entry_shift;

	//----------------------------------------------------------------------
	// matrix table
	//----------------------------------------------------------------------

	always_comb begin
		case (code)
			// row 0 holds the arrows
			sc_left:  entry = {1'b1, 3'd0, 3'd4};
			sc_up:    entry = {1'b1, 3'd0, 3'd5};
			sc_right: entry = {1'b1, 3'd0, 3'd6};
			sc_down:  entry = {1'b1, 3'd0, 3'd7};
			// enter
			8'h5A:    entry = {1'b1, 3'd1, 3'd2};
			// digits
			8'h16:    entry = {1'b1, 3'd2, 3'd1};
			// shifted 2 is the '@' key, unshifted on the Vector
			8'h1E:    entry = shift ? {1'b1, 3'd5, 3'd0} : {1'b1, 3'd2, 3'd2};
			8'h26:    entry = {1'b1, 3'd2, 3'd3};
			8'h4C:    entry = {1'b1, 3'd3, 3'd3};
			// letters
			8'h1C:    entry = {1'b1, 3'd4, 3'd1};
			8'h32:    entry = {1'b1, 3'd4, 3'd2};
			8'h21:    entry = {1'b1, 3'd4, 3'd3};
			8'h23:    entry = {1'b1, 3'd4, 3'd4};
			8'h24:    entry = {1'b1, 3'd4, 3'd5};
			// space
			8'h29:    entry = {1'b1, 3'd7, 3'd7};
			default:  entry = '0;
		endcase
	end

	// keys whose Vector shift state differs from the PC one
	assign entry_shift = (code == 8'h4C && mod_rus) || (code == 8'h1E && shift);

	//----------------------------------------------------------------------
	// registered classification
	//----------------------------------------------------------------------

	always_ff @(posedge clkk) begin
		row           <= entry[5:3];
		col           <= entry[2:0];
		needs_shift   <= entry_shift;
		not_in_matrix <= ~entry[6];
		case (code)
			sc_lshift, sc_rshift:
				key_class <= class_shift;
			sc_ctrl:
				key_class <= class_ctrl;
			sc_rus:
				key_class <= class_rus;
			sc_blksbr:
				key_class <= class_blksbr;
			sc_release, sc_extended:
				key_class <= class_prefix;
			sc_up, sc_down, sc_left, sc_right:
				key_class <= class_arrow;
			default:
				key_class <= entry[6] ? class_matrix : class_none;
		endcase
	end

endmodule

`default_nettype wire

/* src/shift_hold_timer.sv */
//--------------------------------------------------------------------------
// Shift hold timer
// slow tick divider and a retriggerable window that keeps a released
// shift alive for the grey arrow keys
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module shift_hold_timer (
	input  logic clkk,
	input  logic reset,
	input  logic shift_released,
	output logic shift_held
);
	import matrix_pkg::*;

	logic [hold_div_bits-1:0] div_cnt;
	logic slow_tick;
	hold_count_t hold_cnt;

	// free running divider
	always_ff @(posedge clkk) begin
		if (reset)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign slow_tick = (div_cnt == '0);

	// a new release restarts the window
	always_ff @(posedge clkk) begin
		if (reset)
			hold_cnt <= '0;
		else if (shift_released)
			hold_cnt <= hold_ticks;
		else if (slow_tick && hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign shift_held = (hold_cnt != '0);

	// without a reload the count never grows
	assert property (@(posedge clkk) disable iff (reset)
		!shift_released |=> hold_cnt <= $past(hold_cnt));

endmodule

`default_nettype wire

/* src/vector_keyboard.sv */
//--------------------------------------------------------------------------
// Vector-06C keyboard top level
// PS/2 receiver, scan decoder, shift hold timer and matrix controller
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module vector_keyboard (
	input  logic                  clkk,
	input  logic                  reset,
	input  logic                  ps2_clk,
	input  logic                  ps2_dat,
	input  logic                  mod_rus,
	input  matrix_pkg::row_bits_t rowselect,
	output matrix_pkg::row_bits_t rowbits,
	output logic                  key_shift,
	output logic                  key_ctrl,
	output logic                  key_rus,
	output logic                  key_blksbr
);
	import ps2_pkg::*;
	import matrix_pkg::*;

	// receiver handshake
	scan_code_t code;
	logic code_ready;
	logic code_read;

	// decoder results
	key_class_e key_class;
	row_t row;
	col_t col;
	logic needs_shift;
	logic not_in_matrix;

	// shift state
	logic held_shift;
	logic shift_released;
	logic shift_held;

	ps2_receiver ps2_receiver_i (
		.clkk       (clkk),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_dat    (ps2_dat),
		.code       (code),
		.code_ready (code_ready),
		.code_read  (code_read)
	);

	scan_decoder scan_decoder_i (
		.clkk          (clkk),
		.code          (code),
		.shift         (held_shift),
		.mod_rus       (mod_rus),
		.key_class     (key_class),
		.row           (row),
		.col           (col),
		.needs_shift   (needs_shift),
		.not_in_matrix (not_in_matrix)
	);

	shift_hold_timer shift_hold_timer_i (
		.clkk           (clkk),
		.reset          (reset),
		.shift_released (shift_released),
		.shift_held     (shift_held)
	);

	keyboard_matrix keyboard_matrix_i (
		.clkk           (clkk),
		.reset          (reset),
		.code           (code),
		.code_ready     (code_ready),
		.code_read      (code_read),
		.key_class      (key_class),
		.row            (row),
		.col            (col),
		.needs_shift    (needs_shift),
		.not_in_matrix  (not_in_matrix),
		.shift_held     (shift_held),
		.shift_released (shift_released),
		.held_shift     (held_shift),
		.rowselect      (rowselect),
		.rowbits        (rowbits),
		.key_shift      (key_shift),
		.key_ctrl       (key_ctrl),
		.key_rus        (key_rus),
		.key_blksbr     (key_blksbr)
	);

endmodule

`default_nettype wire

/* test/tb_vector_keyboard.sv */
//--------------------------------------------------------------------------
// Vector-06C keyboard testbench
// directed PS/2 traffic against the key matrix, the modifier flags and
// the released-shift hold window
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_vector_keyboard;
	import ps2_pkg::*;
	import matrix_pkg::*;

	// PS/2 half period in clkk cycles
	localparam int half_period = 40;
	// frames sent over all tests, rounded up
	localparam int frame_count = 50;
	// a little over hold_ticks slow ticks
	localparam int hold_window = (int'(hold_ticks) + 2) << hold_div_bits;
	localparam int watchdog_cycles = frame_count * 1000 + hold_window + 20000;

	// keys from the decoder table
	localparam scan_code_t key_a        = 8'h1C;
	localparam scan_code_t key_b        = 8'h32;
	localparam scan_code_t key_1        = 8'h16;
	localparam scan_code_t key_space    = 8'h29;
	localparam scan_code_t key_semi     = 8'h4C;
	localparam scan_code_t key_unmapped = 8'h0E;

	logic clkk;
	logic reset;
	logic ps2_clk;
	logic ps2_dat;
	logic mod_rus;
	row_bits_t rowselect;
	row_bits_t rowbits;
	logic key_shift;
	logic key_ctrl;
	logic key_rus;
	logic key_blksbr;
	logic failed;

	vector_keyboard vector_keyboard_i (
		.clkk       (clkk),
		.reset      (reset),
		.ps2_clk    (ps2_clk),
		.ps2_dat    (ps2_dat),
		.mod_rus    (mod_rus),
		.rowselect  (rowselect),
		.rowbits    (rowbits),
		.key_shift  (key_shift),
		.key_ctrl   (key_ctrl),
		.key_rus    (key_rus),
		.key_blksbr (key_blksbr)
	);

	// 8 ns period
	always #4 clkk = ~clkk;

	//----------------------------------------------------------------------
	// checks
	//----------------------------------------------------------------------

	task automatic stop_on_error(input string why);
		$display("%s", why);
		failed = 1'b1;
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_rowbits(input string name, input row_bits_t got, input row_bits_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL at %0t ns: %s = %02h, expected %02h",
				$time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL at %0t ns: %s = %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_mods(input logic ctrl, input logic rus, input logic blksbr);
		check_flag("key_ctrl", key_ctrl, ctrl);
		check_flag("key_rus", key_rus, rus);
		check_flag("key_blksbr", key_blksbr, blksbr);
	endtask

	//----------------------------------------------------------------------
	// stimulus helpers, all end on a falling edge
	//----------------------------------------------------------------------

	task automatic idle(input int n);
		repeat (n) @(negedge clkk);
	endtask

	// start, 8 data bits LSB first, odd parity, stop
	task automatic send_frame(input scan_code_t value, input logic bad_parity);
		logic [10:0] frame;
		logic par;
		par = ~^value ^ bad_parity;
		frame = {1'b1, par, value, 1'b0};
		idle(1);
		for (int i = 0; i < 11; i++) begin
			// data settles while the clock is high
			ps2_dat = frame[i];
			idle(half_period);
			ps2_clk = 1'b0;
			idle(half_period);
			ps2_clk = 1'b1;
		end
		ps2_dat = 1'b1;
		idle(2 * half_period);
	endtask

	task automatic send_code(input scan_code_t value);
		send_frame(value, 1'b0);
	endtask

	task automatic release_key(input scan_code_t value);
		send_code(sc_release);
		send_code(value);
	endtask

	task automatic press_ext(input scan_code_t value);
		send_code(sc_extended);
		send_code(value);
	endtask

	task automatic release_ext(input scan_code_t value);
		send_code(sc_extended);
		send_code(sc_release);
		send_code(value);
	endtask

	// rowbits is registered, valid one cycle after the select
	task automatic select_and_check(input row_bits_t sel, input row_bits_t exp);
		rowselect = sel;
		idle(1);
		check_rowbits("rowbits", rowbits, exp);
	endtask

	task automatic wait_rowbits(input row_bits_t sel, input row_bits_t exp);
		int n;
		n = 0;
		rowselect = sel;
		idle(1);
		while (rowbits !== exp && n < 2000) begin
			idle(1);
			n++;
		end
		if (rowbits !== exp)
			stop_on_error($sformatf("rowbits never reached %02h for row select %02h in 2000 cycles",
				exp, sel));
	endtask

	//----------------------------------------------------------------------
	// directed tests
	//----------------------------------------------------------------------

	task automatic test_reset_state();
		for (int r = 0; r < matrix_rows; r++)
			select_and_check(row_bits_t'(1) << r, 8'h00);
		check_flag("key_shift", key_shift, 1'b0);
		check_mods(1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_matrix_keys();
		// A row 4 col 1, 1 row 2 col 1, space row 7 col 7
		send_code(key_a);
		wait_rowbits(8'h10, 8'h02);
		send_code(key_1);
		wait_rowbits(8'h04, 8'h02);
		send_code(key_space);
		wait_rowbits(8'h80, 8'h80);
		select_and_check(8'h14, 8'h02);
		select_and_check(8'h94, 8'h82);
		// only the A bit goes away
		release_key(key_a);
		wait_rowbits(8'h10, 8'h00);
		select_and_check(8'h04, 8'h02);
		select_and_check(8'h94, 8'h82);
		release_key(key_1);
		release_key(key_space);
		wait_rowbits(8'hFF, 8'h00);
	endtask

	task automatic test_modifiers();
		send_code(sc_ctrl);
		check_mods(1'b1, 1'b0, 1'b0);
		send_code(sc_rus);
		check_mods(1'b1, 1'b1, 1'b0);
		send_code(sc_blksbr);
		check_mods(1'b1, 1'b1, 1'b1);
		// an ordinary key leaves the flags alone
		send_code(key_b);
		wait_rowbits(8'h10, 8'h04);
		check_mods(1'b1, 1'b1, 1'b1);
		check_flag("key_shift", key_shift, 1'b0);
		release_key(key_b);
		wait_rowbits(8'h10, 8'h00);
		check_mods(1'b1, 1'b1, 1'b1);
		release_key(sc_ctrl);
		check_mods(1'b0, 1'b1, 1'b1);
		release_key(sc_rus);
		check_mods(1'b0, 1'b0, 1'b1);
		release_key(sc_blksbr);
		check_mods(1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_unmapped_and_parity();
		send_code(key_unmapped);
		select_and_check(8'hFF, 8'h00);
		release_key(key_unmapped);
		select_and_check(8'hFF, 8'h00);
		// A with its parity bit flipped is dropped
		send_frame(key_a, 1'b1);
		select_and_check(8'hFF, 8'h00);
		send_code(key_a);
		wait_rowbits(8'h10, 8'h02);
		select_and_check(8'hEF, 8'h00);
		release_key(key_a);
		wait_rowbits(8'hFF, 8'h00);
	endtask

	task automatic test_rus_semicolon();
		mod_rus = 1'b1;
		// semicolon row 3 col 3, shifted in RUS mode
		send_code(key_semi);
		wait_rowbits(8'h08, 8'h08);
		check_flag("key_shift", key_shift, 1'b1);
		release_key(key_semi);
		wait_rowbits(8'h08, 8'h00);
		check_flag("key_shift", key_shift, 1'b0);
		mod_rus = 1'b0;
	endtask

	task automatic test_shift_hold();
		send_code(sc_lshift);
		check_flag("key_shift", key_shift, 1'b1);
		release_key(sc_lshift);
		check_flag("key_shift", key_shift, 1'b0);
		// up arrow inside the window, row 0 col 5
		press_ext(sc_up);
		wait_rowbits(8'h01, 8'h20);
		check_flag("key_shift", key_shift, 1'b1);
		release_ext(sc_up);
		wait_rowbits(8'h01, 8'h00);
		// same sequence, window left to expire first
		send_code(sc_lshift);
		check_flag("key_shift", key_shift, 1'b1);
		release_key(sc_lshift);
		idle(hold_window);
		press_ext(sc_up);
		wait_rowbits(8'h01, 8'h20);
		check_flag("key_shift", key_shift, 1'b0);
		release_ext(sc_up);
		wait_rowbits(8'h01, 8'h00);
	endtask

	//----------------------------------------------------------------------
	// main sequence and watchdog
	//----------------------------------------------------------------------

	initial begin
		clkk      = 1'b0;
		reset     = 1'b1;
		ps2_clk   = 1'b1;
		ps2_dat   = 1'b1;
		mod_rus   = 1'b0;
		rowselect = '0;
		failed    = 1'b0;
		repeat (4) @(negedge clkk);
		reset = 1'b0;
		idle(2);
		test_reset_state();
		test_matrix_keys();
		test_modifiers();
		test_unmapped_and_parity();
		test_rus_semicolon();
		test_shift_hold();
		if (!failed) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clkk);
		$display("watchdog expired after %0d cycles without finishing", watchdog_cycles);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation timed out");
	end

endmodule

`default_nettype wire
